// File: logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data and address width of the integer core
`define CPU_XLEN 32

// Width of a register index and size of the integer register file
`define CPU_REG_ADDR_W 5
`define CPU_NUM_REGS 32

// Address of the first fetch after reset
`define CPU_RESET_PC 32'h0000_0000

// Major opcodes handled by decode
// Register-register ALU group
`define CPU_OPC_OP 7'b0110011
// Register-immediate ALU group
`define CPU_OPC_OP_IMM 7'b0010011
// Load upper immediate
`define CPU_OPC_LUI 7'b0110111

// Cycles from the o_pc request to the matching retire
// One for fetch return, one for decode, one for execute
`define CPU_RETIRE_LATENCY 3

`endif

// File: logic/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

  // Machine word, carries data values and program counters
  typedef logic [`CPU_XLEN-1:0] xlen_t;

  // Register index
  typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

  // Raw instruction word as returned by instruction memory
  typedef logic [31:0] instr_t;

  // ALU operations
  // ALU_PASS_B forwards operand B untouched, used by LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Operand source chosen by the forwarding unit
  typedef enum logic {
    FWD_REG,
    FWD_WB
  } fwd_sel_e;

  // Fetch to decode, instruction paired with its PC
  typedef struct packed {
    logic   valid;
    xlen_t  pc;
    instr_t instr;
  } if_to_id_t;

  // Decode to execute pipeline register
  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    alu_op_e   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      rd_we;
    logic      use_imm;
    xlen_t     imm;
    // Register values read in decode
    xlen_t     rs1_val;
    xlen_t     rs2_val;
  } id_to_ex_t;

  // Execute to writeback pipeline register
  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    reg_addr_t rd;
    logic      rd_we;
    xlen_t     result;
  } ex_to_wb_t;

  // Register file read data for both ports
  typedef struct packed {
    xlen_t rdata1;
    xlen_t rdata2;
  } rf_read_t;

  // Retire report is the writeback record as is
  typedef ex_to_wb_t retire_t;

endpackage : cpu_pkg

// File: logic/fetch_stage.sv
`include "cpu_consts.svh"

module fetch_stage import cpu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  // Instruction memory returns the word for last cycle's o_pc
  input  instr_t    i_instr,
  output xlen_t     o_pc,
  output if_to_id_t o_if_to_id
);

  // PC being requested this cycle
  xlen_t pc_q;
  // PC requested one cycle ago, belongs to i_instr
  xlen_t pc_req_q;
  // Low until the first requested word comes back
  logic  valid_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q     <= `CPU_RESET_PC;
      pc_req_q <= `CPU_RESET_PC;
      valid_q  <= 1'b0;
    end else begin
      // Straight-line sequencing, nothing ever redirects or stalls
      pc_q     <= pc_q + xlen_t'(4);
      pc_req_q <= pc_q;
      valid_q  <= 1'b1;
    end
  end

  assign o_pc = pc_q;

  // Pair the returning word with the address that asked for it
  assign o_if_to_id.valid = valid_q;
  assign o_if_to_id.pc    = pc_req_q;
  assign o_if_to_id.instr = i_instr;

endmodule : fetch_stage

// File: logic/decode_stage.sv
`include "cpu_consts.svh"

module decode_stage import cpu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  if_to_id_t i_if_to_id,
  // Register file read addresses, straight from the instruction
  output reg_addr_t o_rs1_addr,
  output reg_addr_t o_rs2_addr,
  input  rf_read_t  i_rf_read,
  output id_to_ex_t o_id_to_ex
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;

  // Immediates in both supported formats
  xlen_t imm_i;
  xlen_t imm_u;

  // Decoded controls
  alu_op_e   alu_op;
  logic      rd_we;
  logic      use_imm;
  xlen_t     imm;
  id_to_ex_t id_to_ex_q;

  // Shared funct3 decode of the OP and OP-IMM groups
  // alt picks SUB over ADD and SRA over SRL
  function automatic alu_op_e funct_to_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = i_if_to_id.instr[6:0];
  assign rd     = i_if_to_id.instr[11:7];
  assign funct3 = i_if_to_id.instr[14:12];
  assign rs1    = i_if_to_id.instr[19:15];
  assign rs2    = i_if_to_id.instr[24:20];
  assign funct7 = i_if_to_id.instr[31:25];

  // I-type is sign extended from bit 31, U-type fills the low 12 bits with zero
  assign imm_i = {{20{i_if_to_id.instr[31]}}, i_if_to_id.instr[31:20]};
  assign imm_u = {i_if_to_id.instr[31:12], 12'b0};

  always_comb begin
    alu_op  = ALU_ADD;
    rd_we   = 1'b0;
    use_imm = 1'b0;
    imm     = imm_i;
    case (opcode)
      `CPU_OPC_OP: begin
        rd_we  = 1'b1;
        alu_op = funct_to_op(funct3, funct7[5]);
      end
      `CPU_OPC_OP_IMM: begin
        rd_we   = 1'b1;
        use_imm = 1'b1;
        // Only SRAI has an alternate form, ADDI bit 30 is plain immediate
        alu_op  = funct_to_op(funct3, funct7[5] && (funct3 == 3'b101));
      end
      `CPU_OPC_LUI: begin
        rd_we   = 1'b1;
        use_imm = 1'b1;
        imm     = imm_u;
        alu_op  = ALU_PASS_B;
      end
      // Unsupported opcodes flow through and retire with no write
      default: ;
    endcase
  end

  assign o_rs1_addr = rs1;
  assign o_rs2_addr = rs2;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      id_to_ex_q <= '0;
    end else begin
      id_to_ex_q.valid   <= i_if_to_id.valid;
      id_to_ex_q.pc      <= i_if_to_id.pc;
      id_to_ex_q.alu_op  <= alu_op;
      id_to_ex_q.rs1     <= rs1;
      id_to_ex_q.rs2     <= rs2;
      id_to_ex_q.rd      <= rd;
      id_to_ex_q.rd_we   <= rd_we;
      id_to_ex_q.use_imm <= use_imm;
      id_to_ex_q.imm     <= imm;
      // Read data already includes the same-cycle writeback value
      id_to_ex_q.rs1_val <= i_rf_read.rdata1;
      id_to_ex_q.rs2_val <= i_rf_read.rdata2;
    end
  end

  assign o_id_to_ex = id_to_ex_q;

endmodule : decode_stage

// File: logic/regfile.sv
`include "cpu_consts.svh"

module regfile import cpu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  input  logic      i_we,
  input  reg_addr_t i_wr_addr,
  input  xlen_t     i_wr_data,
  output rf_read_t  o_rf_read
);

  xlen_t regs [`CPU_NUM_REGS];

  // x0 reads as zero, a matching write is passed through
  function automatic xlen_t read_port(input reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (i_we && (addr == i_wr_addr)) begin
      return i_wr_data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_wr_addr != '0)) begin
      // Entry 0 is never written and stays zero
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  assign o_rf_read.rdata1 = read_port(i_rs1_addr);
  assign o_rf_read.rdata2 = read_port(i_rs2_addr);

endmodule : regfile

// File: logic/forwarding_unit.sv
module forwarding_unit import cpu_pkg::*; (
  // Instruction currently in execute
  input  id_to_ex_t i_id_to_ex,
  // Instruction currently in writeback
  input  ex_to_wb_t i_ex_to_wb,
  output fwd_sel_e  o_fwd_rs1,
  output fwd_sel_e  o_fwd_rs2
);

  // Writeback produces a usable result this cycle
  logic wb_writes;

  // Source matches the writeback destination
  logic hit_rs1;
  logic hit_rs2;

  // x0 never forwards, its reads stay zero
  assign wb_writes = i_ex_to_wb.valid && i_ex_to_wb.rd_we && (i_ex_to_wb.rd != '0);

  assign hit_rs1 = wb_writes && (i_ex_to_wb.rd == i_id_to_ex.rs1);
  assign hit_rs2 = wb_writes && (i_ex_to_wb.rd == i_id_to_ex.rs2);

  // Older results two back come through the regfile write-through
  // so only the immediately preceding instruction needs a bypass here
  assign o_fwd_rs1 = hit_rs1 ? FWD_WB : FWD_REG;
  assign o_fwd_rs2 = hit_rs2 ? FWD_WB : FWD_REG;

endmodule : forwarding_unit

// File: logic/execute_stage.sv
module execute_stage import cpu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  id_to_ex_t i_id_to_ex,
  // Operand sources from the forwarding unit
  input  fwd_sel_e  i_fwd_rs1,
  input  fwd_sel_e  i_fwd_rs2,
  output ex_to_wb_t o_ex_to_wb
);

  // Writeback register, also the bypass source
  ex_to_wb_t ex_to_wb_q;

  // Forwarded register operands
  xlen_t rs1_fwd;
  xlen_t rs2_fwd;

  // ALU inputs and output
  xlen_t      op_a;
  xlen_t      op_b;
  logic [4:0] shamt;
  xlen_t      alu_res;

  // Pick the writeback result over the stale decode read
  assign rs1_fwd = (i_fwd_rs1 == FWD_WB) ? ex_to_wb_q.result : i_id_to_ex.rs1_val;
  assign rs2_fwd = (i_fwd_rs2 == FWD_WB) ? ex_to_wb_q.result : i_id_to_ex.rs2_val;

  assign op_a = rs1_fwd;
  // Immediate forms replace the second register
  assign op_b = i_id_to_ex.use_imm ? i_id_to_ex.imm : rs2_fwd;

  // Shift amount, upper bits of B are ignored
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_id_to_ex.alu_op)
      ALU_ADD: begin
        alu_res = op_a + op_b;
      end
      ALU_SUB: begin
        alu_res = op_a - op_b;
      end
      ALU_SLL: begin
        alu_res = op_a << shamt;
      end
      // Signed compare
      ALU_SLT: begin
        alu_res = xlen_t'($signed(op_a) < $signed(op_b));
      end
      // Unsigned compare
      ALU_SLTU: begin
        alu_res = xlen_t'(op_a < op_b);
      end
      ALU_XOR: begin
        alu_res = op_a ^ op_b;
      end
      // Logical shift fills with zero
      ALU_SRL: begin
        alu_res = op_a >> shamt;
      end
      // Arithmetic shift keeps the sign
      ALU_SRA: begin
        alu_res = xlen_t'($signed(op_a) >>> shamt);
      end
      ALU_OR: begin
        alu_res = op_a | op_b;
      end
      ALU_AND: begin
        alu_res = op_a & op_b;
      end
      // LUI, the shifted immediate goes through
      ALU_PASS_B: begin
        alu_res = op_b;
      end
      default: begin
        alu_res = '0;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ex_to_wb_q <= '0;
    end else begin
      ex_to_wb_q.valid  <= i_id_to_ex.valid;
      ex_to_wb_q.pc     <= i_id_to_ex.pc;
      ex_to_wb_q.rd     <= i_id_to_ex.rd;
      ex_to_wb_q.rd_we  <= i_id_to_ex.rd_we;
      ex_to_wb_q.result <= alu_res;
    end
  end

  assign o_ex_to_wb = ex_to_wb_q;

endmodule : execute_stage

// File: logic/cpu_top.sv
module cpu_top import cpu_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst_n,
  // Instruction memory, fixed one cycle read latency
  output xlen_t   o_pc,
  input  instr_t  i_instr,
  // One record per completed instruction
  output retire_t o_retire
);

  // Stage to stage records
  if_to_id_t if_to_id;
  id_to_ex_t id_to_ex;
  ex_to_wb_t ex_to_wb;

  // Register file read side
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  rf_read_t  rf_read;

  // Bypass selects into execute
  fwd_sel_e fwd_rs1;
  fwd_sel_e fwd_rs2;

  // Writeback enable, x0 is filtered inside the regfile
  logic rf_we;

  fetch_stage fetch_stage_i (
    .i_clk,
    .i_rst_n,
    .i_instr,
    .o_pc,
    .o_if_to_id (if_to_id)
  );

  // Reads happen here, the values are registered for execute
  decode_stage decode_stage_i (
    .i_clk,
    .i_rst_n,
    .i_if_to_id (if_to_id),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .i_rf_read  (rf_read),
    .o_id_to_ex (id_to_ex)
  );

  assign rf_we = ex_to_wb.valid && ex_to_wb.rd_we;

  regfile regfile_i (
    .i_clk,
    .i_rst_n,
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .i_we       (rf_we),
    .i_wr_addr  (ex_to_wb.rd),
    .i_wr_data  (ex_to_wb.result),
    .o_rf_read  (rf_read)
  );

  forwarding_unit forwarding_unit_i (
    .i_id_to_ex (id_to_ex),
    .i_ex_to_wb (ex_to_wb),
    .o_fwd_rs1  (fwd_rs1),
    .o_fwd_rs2  (fwd_rs2)
  );

  execute_stage execute_stage_i (
    .i_clk,
    .i_rst_n,
    .i_id_to_ex (id_to_ex),
    .i_fwd_rs1  (fwd_rs1),
    .i_fwd_rs2  (fwd_rs2),
    .o_ex_to_wb (ex_to_wb)
  );

  // Writeback record leaves the core as the retire report
  assign o_retire = ex_to_wb;

endmodule : cpu_top

// File: verif/tb_clock.sv
module tb_clock #(
  parameter int period = 8
) (
  output logic o_clk
);

  // Free running clock, low for the first half period
  initial begin
    o_clk = 1'b0;
    forever begin
      #(period / 2) o_clk = ~o_clk;
    end
  end

endmodule : tb_clock

// File: verif/cpu_assertions.sv
`include "cpu_consts.svh"

module cpu_assertions import cpu_pkg::*; (
  input logic    i_clk,
  input logic    i_rst_n,
  input xlen_t   i_pc,
  input retire_t i_retire
);

  // Number of assertion failures so far, read by the testbench
  int fail_count = 0;

  // Nothing may retire while the core is held in reset
  a_no_retire_in_reset : assert property (
    @(posedge i_clk) !i_rst_n |-> !i_retire.valid
  ) else begin
    $error("retire reported during reset");
    fail_count++;
  end

  // Straight-line program, back-to-back retires step by one word
  a_retire_pc_step : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_retire.valid && $past(i_retire.valid)) |-> (i_retire.pc == $past(i_retire.pc) + 32'd4)
  ) else begin
    $error("consecutive retires not 4 apart");
    fail_count++;
  end

  // Fixed latency from request to retire
  a_retire_latency : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_retire.valid |-> (i_retire.pc == $past(i_pc, `CPU_RETIRE_LATENCY))
  ) else begin
    $error("retire pc does not match the request three cycles back");
    fail_count++;
  end

endmodule : cpu_assertions

bind cpu_top cpu_assertions cpu_assertions_i (
  .i_clk    (i_clk),
  .i_rst_n  (i_rst_n),
  .i_pc     (o_pc),
  .i_retire (o_retire)
);

// File: verif/cpu_top_tb.sv
`include "cpu_consts.svh"

module cpu_top_tb import cpu_pkg::*; ;

  localparam int prog_len   = 200;
  localparam int reset_len  = 16;
  // Reset, program, pipeline fill and some slack
  localparam int max_cycles = reset_len + prog_len + `CPU_RETIRE_LATENCY + 20;
  // ADDI x0, x0, 0
  localparam instr_t nop = {12'h000, 5'd0, 3'b000, 5'd0, `CPU_OPC_OP_IMM};

  logic    clk;
  logic    rst_n;
  instr_t  instr;
  xlen_t   pc;
  retire_t retire;

  int      seed = 32'h48bf;
  instr_t  prog_mem [prog_len];
  // Architectural state of the reference model
  xlen_t   model_regs [`CPU_NUM_REGS];
  // Cycle in which each program word was requested
  int      req_cycle [prog_len];
  int      cycle;
  int      checked;
  xlen_t   exp_pc;
  retire_t exp;

  tb_clock #(.period(8)) tb_clock_i (.o_clk(clk));

  cpu_top cpu_top_i (
    .i_clk    (clk),
    .i_rst_n  (rst_n),
    .o_pc     (pc),
    .i_instr  (instr),
    .o_retire (retire)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_xlen(input xlen_t got, input xlen_t want, input string what);
    if (got !== want) begin
      fail_run($sformatf("** Error at time %0t: %s is %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic check_reg_addr(input reg_addr_t got, input reg_addr_t want, input string what);
    if (got !== want) begin
      fail_run($sformatf("** Error at time %0t: %s is x%0d, expected x%0d", $time, what, got, want));
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      fail_run($sformatf("** Error at time %0t: %s is %b, expected %b", $time, what, got, want));
    end
  endtask

  task automatic check_count(input int got, input int want, input string what);
    if (got != want) begin
      fail_run($sformatf("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, want));
    end
  endtask

  // Random OP, OP-IMM and LUI mix over x0 to x7
  // Every eighth slot starts a dependency chain of three
  task automatic build_program();
    reg_addr_t   dest [prog_len];
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    int          form;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [6:0]  f7;
    for (int i = 0; i < prog_len; i++) begin
      form = $unsigned($random(seed)) % 3;
      f3   = 3'($random(seed));
      alt  = 1'($random(seed));
      imm  = 12'($random(seed));
      rd   = reg_addr_t'($unsigned($random(seed)) % 8);
      rs1  = reg_addr_t'($unsigned($random(seed)) % 8);
      rs2  = reg_addr_t'($unsigned($random(seed)) % 8);
      case (i % 8)
        // Chain head writes a real register
        0: rd = reg_addr_t'(1 + $unsigned($random(seed)) % 7);
        // Back to back, served by the writeback bypass
        1: begin
          rs1  = dest[i-1];
          form = 1;
        end
        // Two back through rs2, served by the regfile write-through
        2: begin
          rs1  = dest[i-1];
          rs2  = dest[i-2];
          form = 0;
        end
        default: ;
      endcase
      dest[i] = rd;
      if (form == 0) begin
        f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        prog_mem[i] = {f7, rs2, rs1, f3, rd, `CPU_OPC_OP};
      end else if (form == 1) begin
        // Shift immediates carry funct7 in the upper bits
        if (f3 == 3'b001) begin
          imm = {7'h00, imm[4:0]};
        end else if (f3 == 3'b101) begin
          imm = {(alt ? 7'h20 : 7'h00), imm[4:0]};
        end
        prog_mem[i] = {imm, rs1, f3, rd, `CPU_OPC_OP_IMM};
      end else begin
        prog_mem[i] = {20'($random(seed)), rd, `CPU_OPC_LUI};
      end
    end
  endtask

  // Program words, NOPs past the end
  function automatic instr_t fetch_word(input xlen_t addr);
    if (addr[31:2] < prog_len) begin
      return prog_mem[addr[31:2]];
    end
    return nop;
  endfunction

  // Executes one instruction on the model registers
  function automatic retire_t ref_exec(input instr_t ins, input xlen_t at_pc);
    retire_t    r;
    logic [6:0] opc;
    logic [2:0] f3;
    xlen_t      a;
    xlen_t      b;
    xlen_t      res;
    logic [4:0] sh;
    opc = ins[6:0];
    f3  = ins[14:12];
    a   = model_regs[ins[19:15]];
    if (opc == `CPU_OPC_OP) begin
      b = model_regs[ins[24:20]];
    end else begin
      b = {{20{ins[31]}}, ins[31:20]};
    end
    sh  = b[4:0];
    res = '0;
    if (opc == `CPU_OPC_LUI) begin
      res = {ins[31:12], 12'h000};
    end else begin
      case (f3)
        3'b000: res = (opc == `CPU_OPC_OP && ins[30]) ? a - b : a + b;
        3'b001: res = a << sh;
        // Signs differ means the negative one is smaller
        3'b010: res = xlen_t'((a[31] != b[31]) ? a[31] : (a < b));
        3'b011: res = xlen_t'(a < b);
        3'b100: res = a ^ b;
        // Arithmetic shift fills the vacated top bits with the sign
        3'b101: res = ins[30] ? ((a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0)) : (a >> sh);
        3'b110: res = a | b;
        default: res = a & b;
      endcase
    end
    r.valid  = 1'b1;
    r.pc     = at_pc;
    r.rd     = ins[11:7];
    r.rd_we  = (opc == `CPU_OPC_OP) || (opc == `CPU_OPC_OP_IMM) || (opc == `CPU_OPC_LUI);
    r.result = res;
    if (r.rd_we && r.rd != 0) begin
      model_regs[r.rd] = res;
    end
    return r;
  endfunction

  initial begin
    rst_n   = 1'b0;
    instr   = nop;
    cycle   = 0;
    checked = 0;
    exp_pc  = `CPU_RESET_PC;
    for (int i = 0; i < `CPU_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    build_program();
    repeat (reset_len) @(posedge clk);
    rst_n <= 1'b1;
  end

  // Instruction memory, one cycle read latency
  always @(posedge clk) begin
    instr <= fetch_word(pc);
  end

  // Run length guard
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= max_cycles) begin
      fail_run($sformatf("Timeout: retirement stalled after %0d cycles, %0d of %0d retired",
                         cycle, checked, prog_len));
    end
  end

  // Compare on the falling edge, away from the drive edge
  // The clock settling at time zero is not a sample point
  always @(negedge clk) begin
    if (cycle > 0) begin
      if (cpu_top_i.cpu_assertions_i.fail_count != 0) begin
        fail_run("An assertion bound to cpu_top reported a failure");
      end
      if (!rst_n) begin
        check_xlen(pc, `CPU_RESET_PC, "o_pc in reset");
        check_flag(retire.valid, 1'b0, "retire valid in reset");
      end else begin
        check_xlen(pc, exp_pc, "o_pc");
        exp_pc = exp_pc + 32'd4;
        // Last cycle a word is on o_pc is the one that fetches it
        if (pc[31:2] < prog_len) begin
          req_cycle[pc[31:2]] = cycle;
        end
        if (retire.valid) begin
          exp = ref_exec(prog_mem[checked], xlen_t'(checked * 4));
          check_xlen(retire.pc, exp.pc, "retire pc");
          check_count(cycle, req_cycle[checked] + `CPU_RETIRE_LATENCY, "retire cycle");
          check_reg_addr(retire.rd, exp.rd, "retire rd");
          check_flag(retire.rd_we, exp.rd_we, "retire rd_we");
          check_xlen(retire.result, exp.result, "retire value");
          checked = checked + 1;
          if (checked == prog_len) begin
            $display("Everything OK");
            $finish;
          end
        end
      end
    end
  end

endmodule : cpu_top_tb

// File: tb.f
+incdir+logic
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/regfile.sv
logic/forwarding_unit.sv
logic/execute_stage.sv
logic/cpu_top.sv
verif/tb_clock.sv
verif/cpu_assertions.sv
verif/cpu_top_tb.sv

// File: Bender.yml
package:
  name: cpu_top

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/fetch_stage.sv
      - logic/decode_stage.sv
      - logic/regfile.sv
      - logic/forwarding_unit.sv
      - logic/execute_stage.sv
      - logic/cpu_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/tb_clock.sv
      - verif/cpu_assertions.sv
      - verif/cpu_top_tb.sv
